// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cluster_interco_tb
FILELIST  ?= cluster_interco_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/apb_periph_model.sv ====
`timescale 1ns/100ps

module apb_periph_model import cluster_interco_pkg::*; #(
  parameter int seed_p = 0
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [31:0] err_addr_i,
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o
);

  logic [31:0]             mem [2**(periph_off_w-2)];
  logic [periph_off_w-3:0] word;
  logic [1:0]              wait_q;
  integer                  seed = seed_p;

  assign word = apb_req_i.paddr[periph_off_w-1:2];

  // ready once the drawn wait states have run out
  assign apb_rsp_o.pready  = apb_req_i.psel && apb_req_i.penable && (wait_q == 2'd0);
  assign apb_rsp_o.pslverr = apb_rsp_o.pready && (apb_req_i.paddr == err_addr_i);
  assign apb_rsp_o.prdata  = mem[word];

  always @(posedge clk_i) begin
    if (reset_i) begin
      wait_q <= 2'd0;
    end else if (apb_req_i.psel && !apb_req_i.penable) begin
      // setup phase draws the wait states for this transfer
      wait_q <= 2'($random(seed));
    end else if (apb_req_i.psel && !apb_rsp_o.pready) begin
      wait_q <= wait_q - 2'd1;
    end else if (apb_rsp_o.pready && apb_req_i.pwrite && !apb_rsp_o.pslverr) begin
      mem[word] <= {apb_req_i.pstrb[3] ? apb_req_i.pwdata[31:24] : mem[word][31:24],
                    apb_req_i.pstrb[2] ? apb_req_i.pwdata[23:16] : mem[word][23:16],
                    apb_req_i.pstrb[1] ? apb_req_i.pwdata[15:8]  : mem[word][15:8],
                    apb_req_i.pstrb[0] ? apb_req_i.pwdata[7:0]   : mem[word][7:0]};
    end
  end

endmodule

// ==== bench/cluster_interco_tb.sv ====
`timescale 1ns/100ps

module cluster_interco_tb
  import cluster_interco_pkg::*;
();

  localparam logic [31:0] err_addr   = 32'h0001_0ffc;
  localparam int          seed_init  = 32'h86c518e2;
  localparam int unsigned wait_limit = 64;
  localparam int unsigned tcdm_words = tcdm_size / 4;

  logic               clk;
  logic               reset;
  core_req_t          core_req [n_cores];
  logic [n_cores-1:0] core_gnt;
  core_rsp_t          core_rsp [n_cores];
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;

  integer      seed;
  int unsigned cyc = 0;
  int unsigned psel_cycles = 0;
  int unsigned errors = 0;
  int unsigned errors_at_start = 0;
  int unsigned tests_passed = 0;
  int unsigned tests_failed = 0;
  string       cur_test;

  // reference memories
  logic [31:0] tcdm_model [tcdm_words];
  logic [31:0] periph_model [logic [31:0]];
  logic [31:0] periph_addrs [$];

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (apb_req.psel) begin
      psel_cycles <= psel_cycles + 1;
    end
  end

  cluster_interco_top dut_i (
    .clk_i      ( clk      ),
    .reset_i    ( reset    ),
    .core_req_i ( core_req ),
    .core_gnt_o ( core_gnt ),
    .core_rsp_o ( core_rsp ),
    .apb_req_o  ( apb_req  ),
    .apb_rsp_i  ( apb_rsp  )
  );

  apb_periph_model #(
    .seed_p ( seed_init )
  ) periph_model_i (
    .clk_i      ( clk      ),
    .reset_i    ( reset    ),
    .err_addr_i ( err_addr ),
    .apb_req_i  ( apb_req  ),
    .apb_rsp_o  ( apb_rsp  )
  );

  // ********************************************************************
  // helpers
  // ********************************************************************
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  be);
    return {be[3] ? new_word[31:24] : old_word[31:24], be[2] ? new_word[23:16] : old_word[23:16],
            be[1] ? new_word[15:8] : old_word[15:8], be[0] ? new_word[7:0] : old_word[7:0]};
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s %s: expected %08h, actual %08h", cur_test, what, expected, actual);
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %s: passed", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", cur_test, errors - errors_at_start);
    end
  endtask

  // one request on a core port, latency counted from the grant cycle
  task automatic core_access(input core_id_t core, input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             output logic [31:0] rdata, output logic err,
                             output int latency, output logic done);
    int unsigned waited;
    int unsigned gnt_cyc;
    rdata = 32'h0;
    err = 1'b0;
    latency = 0;
    done = 1'b0;
    @(negedge clk);
    assert (!core_rsp[core].r_valid) else begin
      $display("%s: core %0d got a response with no request outstanding", cur_test, core);
      errors++;
    end
    core_req[core] = '{req: 1'b1, we: we, addr: addr, wdata: wdata, be: be};
    #1;
    waited = 0;
    while (!core_gnt[core] && waited < wait_limit) begin
      @(negedge clk);
      #1;
      waited++;
    end
    assert (core_gnt[core]) else begin
      $display("%s: core %0d was not granted within %0d cycles", cur_test, core, wait_limit);
      errors++;
    end
    if (core_gnt[core]) begin
      gnt_cyc = cyc;
      @(negedge clk);
      core_req[core] = '0;
      #1;
      waited = 0;
      while (!core_rsp[core].r_valid && waited < wait_limit) begin
        @(negedge clk);
        #1;
        waited++;
      end
      assert (core_rsp[core].r_valid) else begin
        $display("%s: core %0d got no response within %0d cycles", cur_test, core, wait_limit);
        errors++;
      end
      if (core_rsp[core].r_valid) begin
        rdata = core_rsp[core].r_rdata;
        err = core_rsp[core].r_err;
        latency = int'(cyc - gnt_cyc);
        done = 1'b1;
      end
    end
  endtask

  task automatic tcdm_access(input core_id_t core, input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be, output int latency);
    logic [31:0] rdata;
    logic        err;
    logic        done;
    logic [7:0]  word;
    word = addr[9:2];
    core_access(core, we, addr, wdata, be, rdata, err, latency, done);
    if (done) begin
      check_value("tcdm r_err", 32'h0, {31'h0, err});
      if (we) begin
        tcdm_model[word] = merge_bytes(tcdm_model[word], wdata, be);
      end else begin
        check_value("tcdm read data", tcdm_model[word], rdata);
      end
    end
  endtask

  task automatic periph_access(input core_id_t core, input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, input logic [3:0] be,
                               input logic expect_err);
    logic [31:0] rdata;
    logic [31:0] old_word;
    logic        err;
    logic        done;
    int          latency;
    core_access(core, we, addr, wdata, be, rdata, err, latency, done);
    if (done) begin
      check_value("apb r_err", {31'h0, expect_err}, {31'h0, err});
      old_word = periph_model.exists(addr) ? periph_model[addr] : 32'h0;
      if (we && !expect_err) begin
        periph_model[addr] = merge_bytes(old_word, wdata, be);
      end else if (!expect_err) begin
        check_value("apb read data", old_word, rdata);
      end
    end
  endtask

  // ********************************************************************
  // test sequence
  // ********************************************************************
  initial begin
    logic [31:0] rnd;
    logic [31:0] addr;
    logic [31:0] addr0;
    logic [31:0] addr1;
    logic [31:0] data;
    logic [31:0] rdata;
    logic [3:0]  be;
    logic        err;
    logic        done;
    int          lat;
    int          lat0;
    int          lat1;
    int unsigned apb_before;
    core_id_t    loser;

    seed = seed_init;
    reset = 1'b1;
    core_req = '{default: '0};
    repeat (4) @(negedge clk);
    reset = 1'b0;

    start_test("reset");
    #1;
    check_value("core_gnt", 32'h0, {30'h0, core_gnt});
    check_value("r_valid", 32'h0, {30'h0, core_rsp[1].r_valid, core_rsp[0].r_valid});
    check_value("psel/penable", 32'h0, {30'h0, apb_req.psel, apb_req.penable});
    end_test();

    start_test("tcdm_random");
    // every word gets a known value first
    for (int unsigned w = 0; w < tcdm_words; w++) begin
      addr = w << 2;
      tcdm_access(w[0], 1'b1, addr, fill_word(addr), 4'hf, lat);
      check_value("fill latency", 32'd2, lat);
    end
    for (int n = 0; n < 48; n++) begin
      rnd = $random(seed);
      data = $random(seed);
      addr = {22'h0, rnd[9:2], 2'b00};
      tcdm_access(rnd[31], rnd[30], addr, data, rnd[29:26], lat);
      check_value("latency", 32'd2, lat);
    end
    end_test();

    start_test("bank_conflict");
    for (int n = 0; n < 8; n++) begin
      rnd = $random(seed);
      data = $random(seed);
      // same bank, neighbouring rows
      addr0 = {22'h0, rnd[9:4], rnd[3:2], 2'b00};
      addr1 = addr0 ^ 32'h10;
      fork
        tcdm_access(1'b0, 1'b1, addr0, data, rnd[29:26], lat0);
        tcdm_access(1'b1, 1'b1, addr1, ~data, rnd[25:22], lat1);
      join
      check_value("winner latency", 32'd2, (lat0 < lat1) ? lat0 : lat1);
      check_value("loser latency", 32'd3, (lat0 < lat1) ? lat1 : lat0);
      loser = (lat0 > lat1) ? 1'b0 : 1'b1;
      fork
        tcdm_access(1'b0, 1'b0, addr0, 32'h0, 4'h0, lat0);
        tcdm_access(1'b1, 1'b0, addr1, 32'h0, 4'h0, lat1);
      join
      check_value("rotated latency", 32'd2, loser ? lat1 : lat0);
    end
    end_test();

    start_test("apb_periph");
    for (int n = 0; n < 32; n++) begin
      rnd = $random(seed);
      data = $random(seed);
      if (rnd[30] || periph_addrs.size() == 0) begin
        addr = periph_base | {20'h0, rnd[5:2], 8'h0};
        // a fresh word gets all bytes so the slave never holds unknown bytes
        be = periph_model.exists(addr) ? rnd[29:26] : 4'hf;
        if (!periph_model.exists(addr)) begin
          periph_addrs.push_back(addr);
        end
        periph_access(rnd[31], 1'b1, addr, data, be, 1'b0);
      end else begin
        addr = periph_addrs[{27'h0, rnd[20:16]} % periph_addrs.size()];
        periph_access(rnd[31], 1'b0, addr, 32'h0, 4'h0, 1'b0);
      end
    end
    fork
      periph_access(1'b0, 1'b0, periph_addrs[0], 32'h0, 4'h0, 1'b0);
      periph_access(1'b1, 1'b0, periph_addrs[periph_addrs.size()-1], 32'h0, 4'h0, 1'b0);
    join
    periph_access(1'b0, 1'b0, err_addr, 32'h0, 4'h0, 1'b1);
    end_test();

    start_test("decode_error");
    apb_before = psel_cycles;
    for (int n = 0; n < 12; n++) begin
      rnd = $random(seed);
      data = $random(seed);
      case (rnd[29:28])
        2'd0: addr = 32'h0000_0400 | {22'h0, rnd[9:2], 2'b00};
        2'd1: addr = 32'h0001_1000 | {22'h0, rnd[9:2], 2'b00};
        default: addr = {rnd[27:12] | 16'h0002, 6'h0, rnd[9:2], 2'b00};
      endcase
      core_access(rnd[31], rnd[30], addr, data, 4'hf, rdata, err, lat, done);
      check_value("r_err", 32'h1, {31'h0, err});
      check_value("error latency", 32'd1, lat);
      // the TCDM word with the same low bits keeps its value
      tcdm_access(rnd[31], 1'b0, {22'h0, addr[9:2], 2'b00}, 32'h0, 4'h0, lat);
    end
    check_value("apb psel cycles", apb_before, psel_cycles);
    end_test();

    repeat (2) @(negedge clk);
    $display("tests: %0d passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== cluster_interco_top.f ====
logic/cluster_interco_pkg.sv
logic/core_req_slot.sv
logic/rr_arbiter.sv
logic/tcdm_bank.sv
logic/periph_apb_master.sv
logic/cluster_interco_top.sv
bench/apb_periph_model.sv
bench/cluster_interco_tb.sv

// ==== logic/cluster_interco_pkg.sv ====
package cluster_interco_pkg;

  // ********************************************************************
  // sizes and address map
  // ********************************************************************
  localparam int unsigned n_cores      = 2;
  localparam int unsigned n_banks      = 4;
  localparam int unsigned bank_words   = 64;
  localparam int unsigned bank_sel_lsb = 2;
  // row bits sit right above the bank select bits
  localparam int unsigned row_lsb      = bank_sel_lsb + $clog2(n_banks);
  localparam int unsigned tcdm_size    = 1024;

  localparam logic [31:0] periph_base  = 32'h0001_0000;
  localparam logic [31:0] periph_size  = 32'h0000_1000;
  localparam int unsigned periph_off_w = $clog2(periph_size);

  typedef logic [$clog2(n_cores)-1:0]    core_id_t;
  typedef logic [$clog2(n_banks)-1:0]    bank_idx_t;
  typedef logic [$clog2(bank_words)-1:0] row_t;

  typedef enum logic [1:0] {
    tgt_bank,
    tgt_periph,
    tgt_error
  } target_e;

  // ********************************************************************
  // core side
  // ********************************************************************
  typedef struct packed {
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } core_req_t;

  typedef struct packed {
    logic        r_valid;
    logic [31:0] r_rdata;
    logic        r_err;
  } core_rsp_t;

  // ********************************************************************
  // bank and peripheral side
  // ********************************************************************
  typedef struct packed {
    logic        we;
    row_t        row;
    logic [31:0] wdata;
    logic [3:0]  be;
    core_id_t    core_id;
  } bank_req_t;

  typedef struct packed {
    logic        r_valid;
    logic [31:0] r_rdata;
    core_id_t    core_id;
  } bank_rsp_t;

  typedef struct packed {
    logic                    we;
    logic [periph_off_w-1:0] paddr;
    logic [31:0]             wdata;
    logic [3:0]              be;
    core_id_t                core_id;
  } periph_req_t;

  typedef struct packed {
    logic        r_valid;
    logic [31:0] r_rdata;
    logic        r_err;
    core_id_t    core_id;
  } periph_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

endpackage

// ==== logic/cluster_interco_top.sv ====
`timescale 1ns/100ps

module cluster_interco_top import cluster_interco_pkg::*; (
  input  logic               clk_i,
  input  logic               reset_i,
  input  core_req_t          core_req_i [n_cores],
  output logic [n_cores-1:0] core_gnt_o,
  output core_rsp_t          core_rsp_o [n_cores],
  output apb_req_t           apb_req_o,
  input  apb_rsp_t           apb_rsp_i
);

  // slot side
  logic [n_cores-1:0] bank_valid;
  bank_idx_t          bank_idx [n_cores];
  bank_req_t          bank_req [n_cores];
  logic [n_cores-1:0] bank_gnt;
  logic [n_cores-1:0] periph_valid;
  periph_req_t        periph_req [n_cores];
  logic [n_cores-1:0] periph_gnt;

  // bank side
  logic [n_cores-1:0] bank_arb_valid [n_banks];
  logic [n_cores-1:0] bank_arb_gnt [n_banks];
  logic [n_banks-1:0] bank_gnt_by_core [n_cores];
  logic               bank_req_valid [n_banks];
  bank_req_t          bank_req_sel [n_banks];
  bank_rsp_t          bank_rsp [n_banks];
  // per core merge of bank responses, one stage per bank
  bank_rsp_t          rsp_chain [n_cores][n_banks+1];

  // peripheral side
  logic               periph_arb_valid;
  periph_req_t        periph_arb_req;
  logic               apb_ready;
  periph_rsp_t        periph_rsp;

  // ********************************************************************
  // request slots
  // ********************************************************************
  for (genvar c = 0; c < n_cores; c++) begin : gen_slot
    assign bank_gnt[c]       = |bank_gnt_by_core[c];
    assign rsp_chain[c][0]   = '0;

    core_req_slot i_slot (
      .clk_i          ( clk_i                  ),
      .reset_i        ( reset_i                ),
      .core_id_i      ( core_id_t'(c)          ),
      .req_i          ( core_req_i[c]          ),
      .gnt_o          ( core_gnt_o[c]          ),
      .rsp_o          ( core_rsp_o[c]          ),
      .bank_valid_o   ( bank_valid[c]          ),
      .bank_idx_o     ( bank_idx[c]            ),
      .bank_req_o     ( bank_req[c]            ),
      .bank_gnt_i     ( bank_gnt[c]            ),
      .periph_valid_o ( periph_valid[c]        ),
      .periph_req_o   ( periph_req[c]          ),
      .periph_gnt_i   ( periph_gnt[c]          ),
      .bank_rsp_i     ( rsp_chain[c][n_banks]  ),
      .periph_rsp_i   ( periph_rsp             )
    );
  end

  // ********************************************************************
  // banks with their arbiters
  // ********************************************************************
  for (genvar b = 0; b < n_banks; b++) begin : gen_bank
    for (genvar c = 0; c < n_cores; c++) begin : gen_route
      assign bank_arb_valid[b][c]   = bank_valid[c] && (bank_idx[c] == bank_idx_t'(b));
      assign bank_gnt_by_core[c][b] = bank_arb_gnt[b][c];
      // two banks may answer two different cores in the same cycle
      assign rsp_chain[c][b+1] = rsp_chain[c][b] |
        ((bank_rsp[b].r_valid && (bank_rsp[b].core_id == core_id_t'(c))) ?
          bank_rsp[b] : bank_rsp_t'('0));
    end

    rr_arbiter #(
      .payload_t ( bank_req_t )
    ) i_bank_arb (
      .clk_i     ( clk_i             ),
      .reset_i   ( reset_i           ),
      .valid_i   ( bank_arb_valid[b] ),
      .payload_i ( bank_req          ),
      .ready_i   ( 1'b1              ),
      .gnt_o     ( bank_arb_gnt[b]   ),
      .valid_o   ( bank_req_valid[b] ),
      .payload_o ( bank_req_sel[b]   )
    );

    tcdm_bank i_bank (
      .clk_i   ( clk_i             ),
      .reset_i ( reset_i           ),
      .valid_i ( bank_req_valid[b] ),
      .req_i   ( bank_req_sel[b]   ),
      .rsp_o   ( bank_rsp[b]       )
    );
  end

  // ********************************************************************
  // peripheral window
  // ********************************************************************
  rr_arbiter #(
    .payload_t ( periph_req_t )
  ) i_periph_arb (
    .clk_i     ( clk_i            ),
    .reset_i   ( reset_i          ),
    .valid_i   ( periph_valid     ),
    .payload_i ( periph_req       ),
    .ready_i   ( apb_ready        ),
    .gnt_o     ( periph_gnt       ),
    .valid_o   ( periph_arb_valid ),
    .payload_o ( periph_arb_req   )
  );

  periph_apb_master i_apb_master (
    .clk_i     ( clk_i            ),
    .reset_i   ( reset_i          ),
    .valid_i   ( periph_arb_valid ),
    .req_i     ( periph_arb_req   ),
    .ready_o   ( apb_ready        ),
    .apb_req_o ( apb_req_o        ),
    .apb_rsp_i ( apb_rsp_i        ),
    .rsp_o     ( periph_rsp       )
  );

endmodule

// ==== logic/core_req_slot.sv ====
`timescale 1ns/100ps

module core_req_slot import cluster_interco_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  core_id_t    core_id_i,
  input  core_req_t   req_i,
  output logic        gnt_o,
  output core_rsp_t   rsp_o,
  output logic        bank_valid_o,
  output bank_idx_t   bank_idx_o,
  output bank_req_t   bank_req_o,
  input  logic        bank_gnt_i,
  output logic        periph_valid_o,
  output periph_req_t periph_req_o,
  input  logic        periph_gnt_i,
  input  bank_rsp_t   bank_rsp_i,
  input  periph_rsp_t periph_rsp_i
);

  logic        busy_q;
  logic        issued_q;
  target_e     target_q;
  logic        we_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic [3:0]  be_q;
  logic        bank_hit;
  logic        periph_hit;
  logic        err_hit;

  function automatic target_e decode(logic [31:0] addr);
    if (addr < 32'(tcdm_size)) begin
      return tgt_bank;
    end else if ((addr >= periph_base) && (addr < periph_base + periph_size)) begin
      return tgt_periph;
    end
    return tgt_error;
  endfunction

  // the slot takes a new request only when empty
  assign gnt_o = req_i.req && !busy_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q   <= 1'b0;
      issued_q <= 1'b0;
      target_q <= tgt_error;
    end else if (gnt_o) begin
      busy_q   <= 1'b1;
      issued_q <= 1'b0;
      target_q <= decode(req_i.addr);
    end else begin
      if (rsp_o.r_valid) begin
        busy_q <= 1'b0;
      end
      if ((bank_valid_o && bank_gnt_i) || (periph_valid_o && periph_gnt_i)) begin
        issued_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      we_q    <= req_i.we;
      addr_q  <= req_i.addr;
      wdata_q <= req_i.wdata;
      be_q    <= req_i.be;
    end
  end

  // ********************************************************************
  // requests toward the arbiters
  // ********************************************************************
  assign bank_valid_o = busy_q && !issued_q && (target_q == tgt_bank);
  assign bank_idx_o   = addr_q[bank_sel_lsb +: $bits(bank_idx_t)];
  assign bank_req_o   = '{we: we_q, row: addr_q[row_lsb +: $bits(row_t)],
                          wdata: wdata_q, be: be_q, core_id: core_id_i};

  assign periph_valid_o = busy_q && !issued_q && (target_q == tgt_periph);
  assign periph_req_o   = '{we: we_q, paddr: addr_q[periph_off_w-1:0],
                            wdata: wdata_q, be: be_q, core_id: core_id_i};

  // ********************************************************************
  // response collection
  // ********************************************************************
  assign bank_hit   = busy_q && bank_rsp_i.r_valid && (bank_rsp_i.core_id == core_id_i);
  assign periph_hit = busy_q && periph_rsp_i.r_valid && (periph_rsp_i.core_id == core_id_i);
  // decode errors answer straight from the slot, one cycle after the grant
  assign err_hit    = busy_q && (target_q == tgt_error);

  assign rsp_o.r_valid = bank_hit || periph_hit || err_hit;
  assign rsp_o.r_rdata = bank_hit ? bank_rsp_i.r_rdata :
                         periph_hit ? periph_rsp_i.r_rdata : 32'h0;
  assign rsp_o.r_err   = err_hit || (periph_hit && periph_rsp_i.r_err);

  // a grant always leaves the port closed in the following cycle
  assert property (@(posedge clk_i) disable iff (reset_i) gnt_o |=> !gnt_o);

  // bank responses only come back to a slot that issued a bank access
  assert property (@(posedge clk_i) disable iff (reset_i)
    (bank_rsp_i.r_valid && (bank_rsp_i.core_id == core_id_i))
      |-> (busy_q && issued_q && (target_q == tgt_bank)));

endmodule

// ==== logic/periph_apb_master.sv ====
`timescale 1ns/100ps

module periph_apb_master import cluster_interco_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        valid_i,
  input  periph_req_t req_i,
  output logic        ready_o,
  output apb_req_t    apb_req_o,
  input  apb_rsp_t    apb_rsp_i,
  output periph_rsp_t rsp_o
);

  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_access
  } state_e;

  state_e      state_q;
  periph_req_t req_q;
  logic        rsp_valid_q;
  logic [31:0] rdata_q;
  logic        err_q;

  assign ready_o = (state_q == st_idle);

  // ********************************************************************
  // APB transfer FSM
  // ********************************************************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= st_idle;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= 1'b0;
      case (state_q)
        st_idle: begin
          if (valid_i) begin
            state_q <= st_setup;
          end
        end
        st_setup: begin
          state_q <= st_access;
        end
        st_access: begin
          // wait states keep us here
          if (apb_rsp_i.pready) begin
            state_q     <= st_idle;
            rsp_valid_q <= 1'b1;
          end
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      req_q <= req_i;
    end
    if ((state_q == st_access) && apb_rsp_i.pready) begin
      rdata_q <= apb_rsp_i.prdata;
      err_q   <= apb_rsp_i.pslverr;
    end
  end

  always_comb begin
    apb_req_o.psel    = (state_q != st_idle);
    apb_req_o.penable = (state_q == st_access);
    apb_req_o.pwrite  = req_q.we;
    apb_req_o.paddr   = periph_base + 32'(req_q.paddr);
    apb_req_o.pwdata  = req_q.wdata;
    // strobes only mean something on writes
    apb_req_o.pstrb   = req_q.we ? req_q.be : 4'h0;
  end

  assign rsp_o = '{r_valid: rsp_valid_q, r_rdata: rdata_q, r_err: err_q,
                   core_id: req_q.core_id};

  // transfer fields hold until the slave completes the access
  assert property (@(posedge clk_i) disable iff (reset_i)
    (apb_req_o.psel && !(apb_req_o.penable && apb_rsp_i.pready))
      |=> (apb_req_o.psel && $stable(apb_req_o.paddr) && $stable(apb_req_o.pwrite)
           && $stable(apb_req_o.pwdata) && $stable(apb_req_o.pstrb)));

endmodule

// ==== logic/rr_arbiter.sv ====
`timescale 1ns/100ps

module rr_arbiter import cluster_interco_pkg::*; #(
  parameter type payload_t = logic
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [n_cores-1:0] valid_i,
  input  payload_t           payload_i [n_cores],
  input  logic               ready_i,
  output logic [n_cores-1:0] gnt_o,
  output logic               valid_o,
  output payload_t           payload_o
);

  // core with the highest priority in the current cycle
  core_id_t prio_q;
  core_id_t win_idx;
  logic     found;

  // ********************************************************************
  // winner search starting at the priority pointer
  // ********************************************************************
  always_comb begin
    int unsigned idx;
    found   = 1'b0;
    win_idx = '0;
    for (int unsigned i = 0; i < n_cores; i++) begin
      idx = (int'(prio_q) + i) % n_cores;
      if (!found && valid_i[idx]) begin
        found   = 1'b1;
        win_idx = core_id_t'(idx);
      end
    end
  end

  always_comb begin
    gnt_o = '0;
    // no grant while the target cannot take the request
    if (found && ready_i) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  assign valid_o   = found;
  assign payload_o = payload_i[win_idx];

  // priority moves past the winner only when another core had to wait
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      prio_q <= '0;
    end else if (found && ready_i && ((valid_i & ~gnt_o) != '0)) begin
      prio_q <= core_id_t'((int'(win_idx) + 1) % n_cores);
    end
  end

  // at most one grant, and only to a requesting core
  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(gnt_o) && ((gnt_o & ~valid_i) == '0));

endmodule

// ==== logic/tcdm_bank.sv ====
`timescale 1ns/100ps

module tcdm_bank import cluster_interco_pkg::*; (
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      valid_i,
  input  bank_req_t req_i,
  output bank_rsp_t rsp_o
);

  logic [31:0] mem_q [bank_words];
  logic        valid_q;
  logic [31:0] rdata_q;
  core_id_t    core_id_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // ********************************************************************
  // single port array, read before write
  // ********************************************************************
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      // writes return the old word, cores drop it
      rdata_q   <= mem_q[req_i.row];
      core_id_q <= req_i.core_id;
      if (req_i.we) begin
        for (int i = 0; i < 4; i++) begin
          if (req_i.be[i]) begin
            mem_q[req_i.row][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end
    end
  end

  assign rsp_o = '{r_valid: valid_q, r_rdata: rdata_q, core_id: core_id_q};

endmodule
